// File: source/busPkg.sv
// bus widths and memory map constants; RAM sits below hexBase and aliases above its own size
package busPkg;

    // CPU data word and byte address widths
    localparam int dataWidth = 16;
    localparam int addrWidth = 16;

    // memory map
    // 0x0000 - 0xff7f  word RAM, aliased above its size
    // 0xff80 - 0xff8f  seven-segment display latch
    // 0xff90 - 0xffff  16450-style UART, eight register offsets

    // first display address, everything below is RAM
    localparam logic [addrWidth-1:0] hexBase = 16'hff80;

    // first UART address, everything from here up is the UART
    localparam logic [addrWidth-1:0] uartBase = 16'hff90;

    // value returned for any read inside the display region,
    // the display latch itself is write only
    localparam logic [dataWidth-1:0] holeReadValue = 16'hcafe;

endpackage

// File: source/uartPkg.sv
// UART register offsets and LSR bit positions; divisor latch, interrupts and FIFOs are not modelled
package uartPkg;

    // register offset width, eight offsets per UART
    localparam int regAddrWidth = 3;

    // THR on write, RBR on read
    localparam logic [regAddrWidth-1:0] offsetData = 3'd0;

    // line control, stored but without effect on any timing
    localparam logic [regAddrWidth-1:0] offsetLineControl = 3'd3;

    // line status, read only
    localparam logic [regAddrWidth-1:0] offsetLineStatus = 3'd5;

    // scratch register
    localparam logic [regAddrWidth-1:0] offsetScratch = 3'd7;

    // LSR bit positions
    localparam int lsrDataReady = 0;
    localparam int lsrThrEmpty = 5;

endpackage

// File: source/busInterfaces.sv
// RAM and UART side buses of the controller; ramPort carries the clock, uartPort has none
`timescale 1ns/1ns

// word-addressed RAM port with two byte lanes
interface ramPort #(
    parameter int ramAddrBits = 10
) (
    input logic clk
);
    logic [ramAddrBits-1:0] wordAddr;
    logic [busPkg::dataWidth-1:0] writeData;
    logic [1:0] byteEnable;
    logic writeEnable;
    logic [busPkg::dataWidth-1:0] readData;

    modport controller (
        input clk,
        output wordAddr, writeData, byteEnable, writeEnable,
        input readData
    );

    modport memory (
        input clk,
        input wordAddr, writeData, byteEnable, writeEnable,
        output readData
    );
endinterface

// byte-wide register port towards the UART
interface uartPort;
    logic [uartPkg::regAddrWidth-1:0] regAddr;
    logic [7:0] writeData;
    logic writeEnable;
    logic readEnable;
    logic chipEnable;
    logic [7:0] readData;

    modport controller (
        output regAddr, writeData, writeEnable, readEnable, chipEnable,
        input readData
    );

    modport device (
        input regAddr, writeData, writeEnable, readEnable, chipEnable,
        output readData
    );
endinterface

// File: source/memoryIo.sv
// address decode and byte steering; byte accesses use the low lane for odd and the high lane for even addresses
`timescale 1ns/1ns

module memoryIo #(
    parameter int ramAddrBits = 10
) (
    input  logic [busPkg::addrWidth-1:0] cpuAddr,
    input  logic [busPkg::dataWidth-1:0] cpuWriteData,
    input  logic                         we,
    input  logic                         re,
    input  logic                         be,
    output logic [busPkg::dataWidth-1:0] cpuReadData,
    ramPort.controller                   ramBus,
    uartPort.controller                  uartBus,
    output logic                         hexWrite
);

    logic regionRam;
    logic regionUart;
    logic regionHex;
    logic [7:0] ramLane;

    // three regions, the display takes what lies between RAM and UART
    assign regionRam = cpuAddr < busPkg::hexBase;
    assign regionUart = cpuAddr >= busPkg::uartBase;
    assign regionHex = !regionRam && !regionUart;

    // byte address to word address, upper bits drop out so the RAM aliases
    assign ramBus.wordAddr = cpuAddr[ramAddrBits:1];
    assign ramBus.writeEnable = we && regionRam;

    // write lane steering
    always_comb begin
        ramBus.writeData = cpuWriteData;
        ramBus.byteEnable = 2'b11;
        if (be) begin
            if (cpuAddr[0]) begin
                // odd address goes to the low byte
                ramBus.writeData = {8'h00, cpuWriteData[7:0]};
                ramBus.byteEnable = 2'b01;
            end else begin
                ramBus.writeData = {cpuWriteData[7:0], 8'h00};
                ramBus.byteEnable = 2'b10;
            end
        end
    end

    // the UART only ever sees the low byte and the low three address bits
    assign uartBus.regAddr = cpuAddr[uartPkg::regAddrWidth-1:0];
    assign uartBus.writeData = cpuWriteData[7:0];
    assign uartBus.chipEnable = regionUart;
    assign uartBus.writeEnable = we && regionUart;
    assign uartBus.readEnable = re && regionUart;

    assign hexWrite = we && regionHex;

    // read path, combinational from address and stored state
    assign ramLane = cpuAddr[0] ? ramBus.readData[7:0] : ramBus.readData[15:8];

    always_comb begin
        if (regionRam) begin
            cpuReadData = be ? {8'h00, ramLane} : ramBus.readData;
        end else if (regionUart) begin
            cpuReadData = {8'h00, uartBus.readData};
        end else begin
            cpuReadData = busPkg::holeReadValue;
        end
    end

    // one write target per edge, across RAM, display and UART
    writeTargetsExclusive: assert property (
        @(posedge ramBus.clk) $onehot0({ramBus.writeEnable, hexWrite, uartBus.writeEnable})
    );

endmodule

// File: source/wordRam.sv
// word RAM of 2**ramAddrBits words; contents are not reset and read is asynchronous
`timescale 1ns/1ns

module wordRam #(
    parameter int ramAddrBits = 10
) (
    ramPort.memory mem
);

    localparam int depth = 2 ** ramAddrBits;

    logic [busPkg::dataWidth-1:0] storage [depth];

    // each lane written on its own enable
    always_ff @(posedge mem.clk) begin
        if (mem.writeEnable) begin
            if (mem.byteEnable[0]) begin
                storage[mem.wordAddr][7:0] <= mem.writeData[7:0];
            end
            if (mem.byteEnable[1]) begin
                storage[mem.wordAddr][15:8] <= mem.writeData[15:8];
            end
        end
    end

    // combinational read of the addressed word
    assign mem.readData = storage[mem.wordAddr];

    // the controller always selects at least one lane on a write
    laneOnWrite: assert property (
        @(posedge mem.clk) mem.writeEnable |-> (mem.byteEnable != 2'b00)
    );

endmodule

// File: source/uartRegs.sv
// 16450-style register block without serial line, baud timing, divisor latch, interrupts or FIFOs
`timescale 1ns/1ns

module uartRegs (
    input  logic       clk,
    input  logic       reset,
    uartPort.device    regs,
    input  logic [7:0] rxData,
    input  logic       rxValid,
    output logic [7:0] txData,
    output logic       txStrobe
);

    logic [7:0] receiveBuffer;
    logic [7:0] lineControl;
    logic [7:0] scratch;
    logic [7:0] lineStatus;
    logic dataReady;
    logic writeAccess;
    logic readAccess;

    assign writeAccess = regs.chipEnable && regs.writeEnable;
    assign readAccess = regs.chipEnable && regs.readEnable;

    // control state
    always_ff @(posedge clk) begin
        if (reset) begin
            txStrobe <= 1'b0;
            lineControl <= 8'h00;
            scratch <= 8'h00;
            dataReady <= 1'b0;
        end else begin
            txStrobe <= writeAccess && (regs.regAddr == uartPkg::offsetData);
            if (writeAccess && regs.regAddr == uartPkg::offsetLineControl) begin
                lineControl <= regs.writeData;
            end
            if (writeAccess && regs.regAddr == uartPkg::offsetScratch) begin
                scratch <= regs.writeData;
            end
            // a new byte wins over a read of the old one on the same edge
            if (rxValid) begin
                dataReady <= 1'b1;
            end else if (readAccess && regs.regAddr == uartPkg::offsetData) begin
                dataReady <= 1'b0;
            end
        end
    end

    // payload bytes
    always_ff @(posedge clk) begin
        if (rxValid) begin
            receiveBuffer <= rxData;
        end
        if (writeAccess && regs.regAddr == uartPkg::offsetData) begin
            txData <= regs.writeData;
        end
    end

    // transmission is instant, so THR is always empty
    always_comb begin
        lineStatus = 8'h00;
        lineStatus[uartPkg::lsrThrEmpty] = 1'b1;
        lineStatus[uartPkg::lsrDataReady] = dataReady;
    end

    always_comb begin
        case (regs.regAddr)
            uartPkg::offsetData:        regs.readData = receiveBuffer;
            uartPkg::offsetLineControl: regs.readData = lineControl;
            uartPkg::offsetLineStatus:  regs.readData = lineStatus;
            uartPkg::offsetScratch:     regs.readData = scratch;
            default:                    regs.readData = 8'h00;
        endcase
    end

    noReadWriteOverlap: assert property (
        @(posedge clk) disable iff (reset) !(regs.readEnable && regs.writeEnable)
    );

endmodule

// File: source/hexDisplay.sv
// display latch with four active-high seven-segment digits, segment a in bit 0 of each digit
`timescale 1ns/1ns

module hexDisplay (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         hexWrite,
    input  logic [busPkg::dataWidth-1:0] writeData,
    output logic [busPkg::dataWidth-1:0] hexValue,
    output logic [27:0]                  hexSegments
);

    // glyph for one nibble, bits gfedcba
    function automatic logic [6:0] glyph(input logic [3:0] nibble);
        case (nibble)
            4'h0: glyph = 7'h3f;
            4'h1: glyph = 7'h06;
            4'h2: glyph = 7'h5b;
            4'h3: glyph = 7'h4f;
            4'h4: glyph = 7'h66;
            4'h5: glyph = 7'h6d;
            4'h6: glyph = 7'h7d;
            4'h7: glyph = 7'h07;
            4'h8: glyph = 7'h7f;
            4'h9: glyph = 7'h6f;
            4'ha: glyph = 7'h77;
            4'hb: glyph = 7'h7c;
            4'hc: glyph = 7'h39;
            4'hd: glyph = 7'h5e;
            4'he: glyph = 7'h79;
            default: glyph = 7'h71;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            hexValue <= '0;
        end else if (hexWrite) begin
            hexValue <= writeData;
        end
    end

    // digit 0 shows the lowest nibble
    always_comb begin
        for (int digit = 0; digit < 4; digit++) begin
            hexSegments[digit*7 +: 7] = glyph(hexValue[digit*4 +: 4]);
        end
    end

endmodule

// File: source/busSystem.sv
// bus subsystem top; ramAddrBits must stay below addrWidth so the word address fits the byte address
`timescale 1ns/1ns

module busSystem #(
    parameter int ramAddrBits = 10
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [busPkg::addrWidth-1:0] cpuAddr,
    input  logic [busPkg::dataWidth-1:0] cpuWriteData,
    output logic [busPkg::dataWidth-1:0] cpuReadData,
    input  logic                         we,
    input  logic                         re,
    input  logic                         be,
    input  logic [7:0]                   rxData,
    input  logic                         rxValid,
    output logic [7:0]                   txData,
    output logic                         txStrobe,
    output logic [busPkg::dataWidth-1:0] hexValue,
    output logic [27:0]                  hexSegments
);

    logic hexWrite;

    ramPort #(.ramAddrBits(ramAddrBits)) ramBus (.clk(clk));
    uartPort uartBus ();

    memoryIo #(.ramAddrBits(ramAddrBits)) controller (
        .cpuAddr      (cpuAddr),
        .cpuWriteData (cpuWriteData),
        .we           (we),
        .re           (re),
        .be           (be),
        .cpuReadData  (cpuReadData),
        .ramBus       (ramBus.controller),
        .uartBus      (uartBus.controller),
        .hexWrite     (hexWrite)
    );

    wordRam #(.ramAddrBits(ramAddrBits)) ram (
        .mem (ramBus.memory)
    );

    uartRegs uart (
        .clk      (clk),
        .reset    (reset),
        .regs     (uartBus.device),
        .rxData   (rxData),
        .rxValid  (rxValid),
        .txData   (txData),
        .txStrobe (txStrobe)
    );

    // the display latches the full CPU word
    hexDisplay display (
        .clk         (clk),
        .reset       (reset),
        .hexWrite    (hexWrite),
        .writeData   (cpuWriteData),
        .hexValue    (hexValue),
        .hexSegments (hexSegments)
    );

endmodule

// File: bench/busSystemTb.sv
// testbench for busSystem with ramAddrBits 10; RAM words are read back only after being written
`timescale 1ns/1ns

module busSystemTb;
    localparam int ramAddrBits = 10;
    localparam int aliasStride = 2 ** (ramAddrBits + 1);
    localparam int strobeTimeout = 8;
    // which output a queued check looks at
    localparam int selRead = 0;
    localparam int selHexValue = 1;
    localparam int selSegments = 2;
    localparam int selTxData = 3;
    localparam int selStrobes = 4;
    // glyphs as gfedcba
    localparam logic [6:0] glyphs [16] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d,
        7'h07, 7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};

    logic clk, reset, we, re, be, rxValid, txStrobe;
    logic [15:0] cpuAddr, cpuWriteData, cpuReadData, hexValue, addr, value;
    logic [7:0] rxData, txData;
    logic [27:0] hexSegments;
    // reference model of the stored state
    logic [15:0] ramModel [2 ** ramAddrBits];
    logic [15:0] hexModel;
    logic [15:0] ramAddrs [16];
    logic [7:0] lcrModel, scratchModel, rbrModel, txModel;
    logic dataReadyModel;
    integer seed;
    int checkCount, errorCount, timeoutCount, strobeCount, expectedStrobes, firstErrors;
    string pendName [$];
    int pendWhich [$];
    logic [31:0] pendExpected [$];

    busSystem #(.ramAddrBits(ramAddrBits)) UUT (.clk(clk), .reset(reset), .cpuAddr(cpuAddr),
        .cpuWriteData(cpuWriteData), .cpuReadData(cpuReadData), .we(we), .re(re), .be(be),
        .rxData(rxData), .rxValid(rxValid), .txData(txData), .txStrobe(txStrobe),
        .hexValue(hexValue), .hexSegments(hexSegments));

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [15:0] randomWord();
        logic [31:0] r;
        r = $random(seed);
        return r[15:0];
    endfunction

    // expected read value from the memory map and byte lane rules
    function automatic logic [15:0] expectedRead(input logic [15:0] a, input logic byteMode);
        logic [15:0] wordAddr;
        logic [15:0] word;
        wordAddr = a >> 1;
        word = ramModel[wordAddr[ramAddrBits-1:0]];
        if (a < busPkg::hexBase) begin
            if (!byteMode) return word;
            return a[0] ? {8'h00, word[7:0]} : {8'h00, word[15:8]};
        end
        if (a < busPkg::uartBase) return 16'hcafe;
        case (a[2:0])
            3'd0: return {8'h00, rbrModel};
            3'd3: return {8'h00, lcrModel};
            3'd5: return {10'h000, 1'b1, 4'h0, dataReadyModel};
            3'd7: return {8'h00, scratchModel};
            default: return 16'h0000;
        endcase
    endfunction

    task automatic updateModel(input logic [15:0] a, input logic [15:0] d, input logic byteMode);
        logic [15:0] wordAddr;
        wordAddr = a >> 1;
        if (a < busPkg::hexBase) begin
            if (!byteMode) ramModel[wordAddr[ramAddrBits-1:0]] = d;
            else if (a[0]) ramModel[wordAddr[ramAddrBits-1:0]][7:0] = d[7:0];
            else ramModel[wordAddr[ramAddrBits-1:0]][15:8] = d[7:0];
        end else if (a < busPkg::uartBase) begin
            hexModel = d;
        end else begin
            case (a[2:0])
                3'd0: txModel = d[7:0];
                3'd3: lcrModel = d[7:0];
                3'd7: scratchModel = d[7:0];
                default: ;
            endcase
        end
    endtask

    task automatic queueCheck(input string name, input int which, input logic [31:0] expected);
        pendName.push_back(name);
        pendWhich.push_back(which);
        pendExpected.push_back(expected);
    endtask

    task automatic busWrite(input logic [15:0] a, input logic [15:0] d, input logic byteMode);
        @(posedge clk);
        cpuAddr <= a;
        cpuWriteData <= d;
        be <= byteMode;
        we <= 1'b1;
        re <= 1'b0;
        updateModel(a, d, byteMode);
    endtask

    task automatic busRead(input logic [15:0] a, input logic byteMode, input string name);
        @(posedge clk);
        cpuAddr <= a;
        be <= byteMode;
        we <= 1'b0;
        re <= 1'b1;
        queueCheck(name, selRead, {16'h0000, expectedRead(a, byteMode)});
        // reading RBR clears data ready at the next edge
        if (a >= busPkg::uartBase && a[2:0] == 3'd0) dataReadyModel = 1'b0;
    endtask

    task automatic idle();
        @(posedge clk);
        we <= 1'b0;
        re <= 1'b0;
        rxValid <= 1'b0;
    endtask

    task automatic receiveByte(input logic [7:0] b);
        @(posedge clk);
        rxData <= b;
        rxValid <= 1'b1;
        we <= 1'b0;
        re <= 1'b0;
        idle();
        rbrModel = b;
        dataReadyModel = 1'b1;
    endtask

    task automatic awaitTxStrobe();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (txStrobe !== 1'b1 && cycles < strobeTimeout);
        assert (txStrobe === 1'b1) else begin
            timeoutCount++;
            $display("txStrobe did not pulse within %0d cycles after a THR write",
                strobeTimeout);
        end
        // the strobe belongs to the cycle right after the THR write edge
        assert (txStrobe !== 1'b1 || cycles == 1) else begin
            errorCount++;
            $display("** Error txStrobe delay: expected %0d, actual %0d", 1, cycles);
        end
    endtask

    task automatic finishTest(input string name);
        idle();
        $display("test %s: %s", name,
            (errorCount + timeoutCount == firstErrors) ? "ok" : "failed");
        firstErrors = errorCount + timeoutCount;
    endtask

    // compares queued expectations once the outputs have settled
    always @(negedge clk) begin : compare
        string name;
        int which;
        logic [31:0] expected;
        logic [31:0] actual;
        if (!reset && txStrobe === 1'b1) strobeCount++;
        while (pendWhich.size() > 0) begin
            name = pendName.pop_front();
            which = pendWhich.pop_front();
            expected = pendExpected.pop_front();
            case (which)
                selRead: actual = {16'h0000, cpuReadData};
                selHexValue: actual = {16'h0000, hexValue};
                selSegments: actual = {4'h0, hexSegments};
                selTxData: actual = {24'h000000, txData};
                default: actual = 32'(strobeCount);
            endcase
            checkCount++;
            assert (actual === expected) else begin
                errorCount++;
                $display("** Error %s: expected %h, actual %h", name, expected, actual);
            end
        end
    end

    initial begin
        seed = 99;
        reset = 1'b1;
        we = 1'b0;
        re = 1'b0;
        be = 1'b0;
        rxValid = 1'b0;
        cpuAddr = '0;
        cpuWriteData = '0;
        rxData = '0;
        hexModel = '0;
        lcrModel = '0;
        scratchModel = '0;
        dataReadyModel = 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        for (int i = 0; i < 16; i++) begin
            ramAddrs[i] = (randomWord() % busPkg::hexBase) & 16'hfffe;
            busWrite(ramAddrs[i], randomWord(), 1'b0);
        end
        for (int i = 0; i < 16; i++) begin
            busRead(ramAddrs[i], 1'b0, "word readback");
            // same word seen through an address one RAM size away
            if (int'(ramAddrs[i]) + aliasStride < int'(busPkg::hexBase)) begin
                busRead(16'(int'(ramAddrs[i]) + aliasStride), 1'b0, "word alias");
            end else begin
                busRead(16'(int'(ramAddrs[i]) - aliasStride), 1'b0, "word alias");
            end
        end
        finishTest("word RAM");

        for (int i = 0; i < 4; i++) begin
            addr = (randomWord() % busPkg::hexBase) & 16'hfffe;
            busWrite(addr, randomWord(), 1'b0);
            busWrite(addr + 16'd1, randomWord(), 1'b1);
            busRead(addr, 1'b0, "odd byte write");
            busWrite(addr, randomWord(), 1'b1);
            busRead(addr, 1'b0, "even byte write");
            busRead(addr, 1'b1, "even byte read");
            busRead(addr + 16'd1, 1'b1, "odd byte read");
        end
        finishTest("byte access");

        queueCheck("display after reset", selHexValue, {16'h0000, hexModel});
        for (int i = 0; i < 2; i++) begin
            busWrite(busPkg::hexBase + 16'd5, randomWord(), 1'b0);
            idle();
            queueCheck("display value", selHexValue, {16'h0000, hexModel});
            queueCheck("display segments", selSegments, {4'h0, glyphs[hexModel[15:12]],
                glyphs[hexModel[11:8]], glyphs[hexModel[7:4]], glyphs[hexModel[3:0]]});
        end
        busRead(busPkg::hexBase + 16'd9, 1'b0, "display word read");
        busRead(busPkg::hexBase + 16'd4, 1'b1, "display byte read");
        finishTest("display");

        busRead(busPkg::uartBase + 16'd3, 1'b0, "LCR after reset");
        busRead(busPkg::uartBase + 16'd7, 1'b0, "scratch after reset");
        busWrite(busPkg::uartBase + 16'd3, randomWord(), 1'b0);
        busWrite(busPkg::uartBase + 16'd7, randomWord(), 1'b0);
        busRead(16'hfffb, 1'b0, "LCR readback");
        busRead(16'hffff, 1'b1, "scratch readback");
        busRead(busPkg::uartBase + 16'd1, 1'b0, "unused offset 1");
        busRead(busPkg::uartBase + 16'd2, 1'b0, "unused offset 2");
        busRead(busPkg::uartBase + 16'd4, 1'b0, "unused offset 4");
        busRead(busPkg::uartBase + 16'd6, 1'b0, "unused offset 6");
        busRead(busPkg::uartBase + 16'd5, 1'b0, "LSR idle");
        finishTest("UART registers");

        for (int i = 0; i < 2; i++) begin
            busWrite(busPkg::uartBase, randomWord(), 1'b0);
            idle();
            expectedStrobes++;
            awaitTxStrobe();
            idle();
            queueCheck("txData", selTxData, {24'h000000, txModel});
            repeat (3) idle();
            queueCheck("txStrobe count", selStrobes, 32'(expectedStrobes));
        end
        finishTest("UART transmit");

        for (int i = 0; i < 2; i++) begin
            value = randomWord();
            receiveByte(value[7:0]);
            busRead(busPkg::uartBase + 16'd5, 1'b0, "LSR data ready");
            busRead(busPkg::uartBase, 1'b0, "RBR read");
            busRead(busPkg::uartBase + 16'd5, 1'b0, "LSR after RBR read");
        end
        finishTest("UART receive");

        $display("tests 6, checks %0d, errors %0d", checkCount, errorCount + timeoutCount);
        if (errorCount + timeoutCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end
endmodule

// File: all.f
source/busPkg.sv
source/uartPkg.sv
source/busInterfaces.sv
source/memoryIo.sv
source/wordRam.sv
source/uartRegs.sv
source/hexDisplay.sv
source/busSystem.sv
bench/busSystemTb.sv

// File: run.sh
#!/bin/sh
# compiles and runs the bus subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f all.f --top-module busSystemTb -o busSystemTb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi
./obj_dir/busSystemTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi
exit 0
